//--- sim/vgaPatternTb.sv
`timescale 1ns/1ps

module vgaPatternTb;

   import vgaPkg::*;

   // Tiny frame of 26 counts per line and 12 lines
   localparam int hPulse = 4;
   localparam int hBack = 3;
   localparam int barCounts = 2;
   localparam int hTotal = 26;
   localparam int vPulse = 2;
   localparam int vBack = 2;
   localparam int vActive = 6;
   localparam int vTotal = 12;
   localparam int hStart = hPulse + hBack;
   localparam int hEnd = hStart + 8 * barCounts;
   localparam int vStart = vPulse + vBack;
   localparam int vEnd = vStart + vActive;
   localparam int frameLen = hTotal * vTotal;
   localparam int numEntries = 8;
   // Reset frame plus two frames per table entry
   localparam int watchdogCycles = (numEntries + 1) * 2 * frameLen + 100;

   typedef struct packed {
      logic [3:0] addr;
      logic [31:0] data;
      logic [3:0] strb;
      axiResp bResp;
      logic [31:0] rdData;
      axiResp rResp;
   } stimEntry;

   // Address, write data, strobes, write response, read-back data, read response
   stimEntry stimTable [numEntries] = '{
      '{4'h0, 32'h0000_0009, 4'hF, respOkay, 32'h0000_0009, respOkay},
      '{4'h0, 32'hFFFF_FF3C, 4'hF, respOkay, 32'h0000_003C, respOkay},
      '{4'h0, 32'h0000_001B, 4'hE, respOkay, 32'h0000_003C, respOkay},
      '{4'h4, 32'h0000_0006, 4'hF, respSlvErr, 32'h0000_0000, respSlvErr},
      '{4'h0, 32'h0000_0036, 4'h1, respOkay, 32'h0000_0036, respOkay},
      '{4'h8, 32'h0000_0000, 4'hF, respSlvErr, 32'h0000_0000, respSlvErr},
      '{4'h0, 32'h0000_0012, 4'h0, respOkay, 32'h0000_0036, respOkay},
      '{4'h0, 32'h0000_0024, 4'hF, respOkay, 32'h0000_0024, respOkay}
   };

   logic GCLK = 1'b0;
   logic rstN;
   logic awValid, awReady, wValid, wReady, bValid, bReady;
   logic arValid, arReady, rValid, rReady;
   logic [3:0] awAddr, arAddr, wStrb;
   logic [31:0] wData, rData;
   axiResp bResp, rResp;
   logic vgaHs, vgaVs;
   colorLevel vgaR, vgaG, vgaB;

   // Model state
   int cyc = 0;
   int pix;
   logic [5:0] expSel;
   bit colorArmed = 1'b0;
   int colorLeft = 0;

   vgaPatternTop #(
      .hPulse(hPulse), .hBack(hBack), .hTotal(hTotal), .barCounts(barCounts),
      .vPulse(vPulse), .vBack(vBack), .vActive(vActive), .vTotal(vTotal)
   ) vgaPatternTop_i (
      .GCLK(GCLK), .rstN(rstN),
      .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
      .wValid(wValid), .wReady(wReady), .wData(wData), .wStrb(wStrb),
      .bValid(bValid), .bReady(bReady), .bResp(bResp),
      .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
      .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
      .vgaHs(vgaHs), .vgaVs(vgaVs), .vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB)
   );

   always #50 GCLK = ~GCLK;

   task automatic abortRun();
      $display("Finished with errors");
      $fatal(1, "Run stopped");
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
         abortRun();
      end
   endtask

   task automatic checkLevel(input string name, input colorLevel got, input colorLevel exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         abortRun();
      end
   endtask

   task automatic checkResp(input string name, input axiResp got, input axiResp exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
         abortRun();
      end
   endtask

   task automatic checkData(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         abortRun();
      end
   endtask

   // Lit when the selected bit of the bar number is set
   function automatic colorLevel expectLevel(input int h, input bit inWin, input barSel s);
      int barNum;
      if (!inWin || s == selOff)
         return 4'h0;
      barNum = (h - hStart) / barCounts;
      return barNum[s] ? fullLevel : 4'h0;
   endfunction

   task automatic comparePins(input int p, input bit withColor);
      int h;
      int v;
      bit inWin;
      // Empty pipeline looks like blanking with both syncs idle
      h = (p < 0) ? hPulse : p % hTotal;
      v = (p < 0) ? vPulse : (p / hTotal) % vTotal;
      inWin = h >= hStart && h < hEnd && v >= vStart && v < vEnd;
      checkBit("vgaHs", vgaHs, h >= hPulse);
      checkBit("vgaVs", vgaVs, v >= vPulse);
      // Blanking always dark and the visible area checked only in armed frames
      if (withColor || !inWin) begin
         checkLevel("vgaR", vgaR, expectLevel(h, inWin, expSel[1:0]));
         checkLevel("vgaG", vgaG, expectLevel(h, inWin, expSel[3:2]));
         checkLevel("vgaB", vgaB, expectLevel(h, inWin, expSel[5:4]));
      end
   endtask

   // Counter index 0 in the first cycle after reset
   always @(posedge GCLK) begin
      if (!rstN)
         cyc <= 0;
      else
         cyc <= cyc + 1;
   end

   // Pins trail the counters by three cycles
   always @(negedge GCLK) begin
      if (cyc > 0) begin
         pix = cyc - 3;
         if (colorArmed && pix >= 0 && pix % frameLen == 0) begin
            colorLeft = frameLen;
            colorArmed = 1'b0;
         end
         comparePins(pix, colorLeft > 0);
         if (colorLeft > 0)
            colorLeft = colorLeft - 1;
      end
   end

   // Next full frame gets its colours checked too
   task automatic checkOneFrame();
      colorArmed = 1'b1;
      wait (!colorArmed);
      wait (colorLeft == 0);
   endtask

   task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output axiResp resp);
      int delay;
      delay = $urandom_range(3, 0);
      awAddr = addr;
      wData = data;
      wStrb = strb;
      awValid = 1'b1;
      wValid = 1'b1;
      do @(negedge GCLK); while (!awReady);
      // Data channel accepted together with the address
      checkBit("wReady", wReady, 1'b1);
      @(negedge GCLK);
      awValid = 1'b0;
      wValid = 1'b0;
      while (!bValid)
         @(negedge GCLK);
      // Response must wait for the master
      repeat (delay) begin
         @(negedge GCLK);
         if (!bValid) begin
            $display("Write response dropped before bReady at %0t", $time);
            abortRun();
         end
      end
      resp = bResp;
      bReady = 1'b1;
      @(negedge GCLK);
      bReady = 1'b0;
   endtask

   task automatic axiRead(input logic [3:0] addr, output logic [31:0] data,
                          output axiResp resp);
      int delay;
      delay = $urandom_range(3, 0);
      arAddr = addr;
      arValid = 1'b1;
      do @(negedge GCLK); while (!arReady);
      @(negedge GCLK);
      arValid = 1'b0;
      while (!rValid)
         @(negedge GCLK);
      repeat (delay) begin
         @(negedge GCLK);
         if (!rValid) begin
            $display("Read data dropped before rReady at %0t", $time);
            abortRun();
         end
      end
      data = rData;
      resp = rResp;
      rReady = 1'b1;
      @(negedge GCLK);
      rReady = 1'b0;
   endtask

   initial begin
      #(watchdogCycles * 100);
      $display("Timeout, the test did not finish within %0d cycles", watchdogCycles);
      abortRun();
   end

   initial begin
      axiResp resp;
      logic [31:0] data;
      void'($urandom(44));
      rstN = 1'b0;
      {awValid, wValid, bReady, arValid, rReady} = '0;
      awAddr = '0;
      arAddr = '0;
      wData = '0;
      wStrb = '0;
      expSel = ctrlResetValue;
      repeat (16) @(negedge GCLK);
      rstN = 1'b1;
      // Reset pattern before any write
      checkOneFrame();
      for (int i = 0; i < numEntries; i++) begin
         axiWrite(stimTable[i].addr, stimTable[i].data, stimTable[i].strb, resp);
         checkResp("bResp", resp, stimTable[i].bResp);
         if (stimTable[i].addr == ctrlAddr && stimTable[i].strb[0])
            expSel = stimTable[i].data[5:0];
         axiRead(stimTable[i].addr, data, resp);
         checkData("rData", data, stimTable[i].rdData);
         checkResp("rResp", resp, stimTable[i].rResp);
         checkOneFrame();
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule : vgaPatternTb

//--- src.f
src/vgaPkg.sv
src/ctrlRegSlave.sv
src/syncTiming.sv
src/colorChannel.sv
src/pixelOutput.sv
src/vgaPatternTop.sv
sim/vgaPatternTb.sv

//--- src/colorChannel.sv
`timescale 1ns/1ps

module colorChannel (
   input  logic GCLK,
   input  logic rstN,
   input  vgaPkg::barIndex bar,
   input  logic active,
   input  vgaPkg::barSel sel,
   output vgaPkg::colorLevel level
);

   import vgaPkg::*;

   logic lit;

   // Lit when the chosen bar bit is set inside the visible area
   always_comb begin
      lit = 1'b0;
      if (active && sel != selOff)
         lit = bar[sel];
   end

   // One register stage after the timing decodes
   always_ff @(posedge GCLK) begin
      if (!rstN)
         level <= '0;
      else
         level <= lit ? fullLevel : colorLevel'(0);
   end

endmodule : colorChannel

//--- src/ctrlRegSlave.sv
`timescale 1ns/1ps

module ctrlRegSlave (
   input  logic GCLK,
   input  logic rstN,
   // Write address and data
   input  logic awValid,
   output logic awReady,
   input  logic [3:0] awAddr,
   input  logic wValid,
   output logic wReady,
   input  logic [31:0] wData,
   input  logic [3:0] wStrb,
   // Write response
   output logic bValid,
   input  logic bReady,
   output vgaPkg::axiResp bResp,
   // Read address
   input  logic arValid,
   output logic arReady,
   input  logic [3:0] arAddr,
   // Read data
   output logic rValid,
   input  logic rReady,
   output logic [31:0] rData,
   output vgaPkg::axiResp rResp,
   // Register contents, two bits per channel
   output logic [2*vgaPkg::numChannels-1:0] chanSel
);

   import vgaPkg::*;

   logic wrAccept;
   logic wrFire;
   logic rdFire;

   // Address and data are accepted in the same cycle
   assign awReady = wrAccept;
   assign wReady = wrAccept;

   assign wrFire = awValid && awReady && wValid && wReady;
   assign rdFire = arValid && arReady;

   // Write channel
   always_ff @(posedge GCLK) begin
      if (!rstN) begin
         wrAccept <= 1'b0;
         bValid <= 1'b0;
         chanSel <= ctrlResetValue;
      end else begin
         // One-cycle ready pulse, held off while a response waits
         wrAccept <= awValid && wValid && !bValid && !wrAccept;
         if (wrFire) begin
            bValid <= 1'b1;
            // Only byte lane 0 holds register bits
            if (awAddr == ctrlAddr && wStrb[0])
               chanSel <= wData[2*numChannels-1:0];
         end else if (bValid && bReady) begin
            bValid <= 1'b0;
         end
      end
   end

   // Response code captured at the handshake
   always_ff @(posedge GCLK) begin
      if (wrFire)
         bResp <= (awAddr == ctrlAddr) ? respOkay : respSlvErr;
   end

   // Read channel
   always_ff @(posedge GCLK) begin
      if (!rstN) begin
         arReady <= 1'b0;
         rValid <= 1'b0;
      end else begin
         arReady <= arValid && !rValid && !arReady;
         if (rdFire)
            rValid <= 1'b1;
         else if (rValid && rReady)
            rValid <= 1'b0;
      end
   end

   // Read payload, zero for unmapped addresses
   always_ff @(posedge GCLK) begin
      if (rdFire) begin
         rData <= (arAddr == ctrlAddr) ? 32'(chanSel) : '0;
         rResp <= (arAddr == ctrlAddr) ? respOkay : respSlvErr;
      end
   end

   // Response held until the master takes it
   assert property (@(posedge GCLK) disable iff (!rstN)
      bValid && !bReady |=> bValid);

   // No new write accepted over a pending response
   assert property (@(posedge GCLK) disable iff (!rstN)
      !(awReady && bValid));

endmodule : ctrlRegSlave

//--- src/pixelOutput.sv
`timescale 1ns/1ps

module pixelOutput (
   input  logic GCLK,
   input  logic rstN,
   input  logic hSyncRaw,
   input  logic vSyncRaw,
   input  vgaPkg::colorLevel redIn,
   input  vgaPkg::colorLevel greenIn,
   input  vgaPkg::colorLevel blueIn,
   output logic vgaHs,
   output logic vgaVs,
   output vgaPkg::colorLevel vgaR,
   output vgaPkg::colorLevel vgaG,
   output vgaPkg::colorLevel vgaB
);

   // Syncs one stage behind, matching the channel register
   logic hsDly;
   logic vsDly;

   always_ff @(posedge GCLK) begin
      if (!rstN) begin
         hsDly <= 1'b1;
         vsDly <= 1'b1;
      end else begin
         hsDly <= hSyncRaw;
         vsDly <= vSyncRaw;
      end
   end

   // Pin registers
   // Syncs idle high, colours dark
   always_ff @(posedge GCLK) begin
      if (!rstN) begin
         vgaHs <= 1'b1;
         vgaVs <= 1'b1;
         vgaR <= '0;
         vgaG <= '0;
         vgaB <= '0;
      end else begin
         vgaHs <= hsDly;
         vgaVs <= vsDly;
         vgaR <= redIn;
         vgaG <= greenIn;
         vgaB <= blueIn;
      end
   end

   // Colour stays dark during either sync pulse
   assert property (@(posedge GCLK) disable iff (!rstN)
      (!vgaHs || !vgaVs) |-> (vgaR == '0 && vgaG == '0 && vgaB == '0));

endmodule : pixelOutput

//--- src/syncTiming.sv
`timescale 1ns/1ps

module syncTiming #(
   parameter int hPulse = 192,
   parameter int hBack = 96,
   parameter int hTotal = 1600,
   parameter int vPulse = 2,
   parameter int vBack = 29,
   parameter int vActive = 480,
   parameter int vTotal = 521,
   parameter int barCounts = 160
) (
   input  logic GCLK,
   input  logic rstN,
   output logic hSyncRaw,
   output logic vSyncRaw,
   output logic active,
   output vgaPkg::barIndex bar
);

   import vgaPkg::*;

   localparam int hWidth = $clog2(hTotal);
   localparam int vWidth = $clog2(vTotal);
   localparam int wWidth = $clog2(barCounts + 1);
   // Visible window bounds, end exclusive
   localparam int hStart = hPulse + hBack;
   localparam int hEnd = hStart + 8 * barCounts;
   localparam int vStart = vPulse + vBack;
   localparam int vEnd = vStart + vActive;

   logic [hWidth-1:0] hCount;
   logic [vWidth-1:0] vCount;
   logic [wWidth-1:0] widthCnt;
   logic hInWin;
   logic vInWin;
   barIndex barNext;

   // Frame counters, vertical steps on horizontal wrap
   always_ff @(posedge GCLK) begin
      if (!rstN) begin
         hCount <= '0;
         vCount <= '0;
      end else if (hCount == hWidth'(hTotal - 1)) begin
         hCount <= '0;
         vCount <= (vCount == vWidth'(vTotal - 1)) ? '0 : vCount + 1'b1;
      end else begin
         hCount <= hCount + 1'b1;
      end
   end

   assign hInWin = (hCount >= hStart) && (hCount < hEnd);
   assign vInWin = (vCount >= vStart) && (vCount < vEnd);

   // Bar steps once the width counter runs out
   always_comb begin
      barNext = '0;
      if (hInWin && vInWin && hCount != hStart)
         barNext = (widthCnt == '0) ? bar + 1'b1 : bar;
   end

   // Registered decodes, one cycle behind the counters
   always_ff @(posedge GCLK) begin
      if (!rstN) begin
         hSyncRaw <= 1'b1;
         vSyncRaw <= 1'b1;
         active <= 1'b0;
         bar <= '0;
         widthCnt <= '0;
      end else begin
         hSyncRaw <= !(hCount < hPulse);
         vSyncRaw <= !(vCount < vPulse);
         active <= hInWin && vInWin;
         bar <= barNext;
         // Reload at line start and at each bar edge
         if (!(hInWin && vInWin) || hCount == hStart || widthCnt == '0)
            widthCnt <= wWidth'(barCounts - 1);
         else
            widthCnt <= widthCnt - 1'b1;
      end
   end

   // Bar index frozen during blanking
   assert property (@(posedge GCLK) disable iff (!rstN)
      !active ##1 !active |-> $stable(bar));

endmodule : syncTiming

//--- src/vgaPatternTop.sv
`timescale 1ns/1ps

module vgaPatternTop #(
   parameter int hPulse = 192,
   parameter int hBack = 96,
   parameter int hTotal = 1600,
   parameter int barCounts = 160,
   parameter int vPulse = 2,
   parameter int vBack = 29,
   parameter int vActive = 480,
   parameter int vTotal = 521
) (
   input  logic GCLK,
   input  logic rstN,
   // AXI4-Lite control port
   input  logic awValid,
   output logic awReady,
   input  logic [3:0] awAddr,
   input  logic wValid,
   output logic wReady,
   input  logic [31:0] wData,
   input  logic [3:0] wStrb,
   output logic bValid,
   input  logic bReady,
   output vgaPkg::axiResp bResp,
   input  logic arValid,
   output logic arReady,
   input  logic [3:0] arAddr,
   output logic rValid,
   input  logic rReady,
   output logic [31:0] rData,
   output vgaPkg::axiResp rResp,
   // VGA pins
   output logic vgaHs,
   output logic vgaVs,
   output vgaPkg::colorLevel vgaR,
   output vgaPkg::colorLevel vgaG,
   output vgaPkg::colorLevel vgaB
);

   import vgaPkg::*;

   logic [2*numChannels-1:0] chanSel;
   logic hSyncRaw;
   logic vSyncRaw;
   logic active;
   barIndex bar;
   // Index 0 red, 1 green, 2 blue
   colorLevel chanLevel [numChannels];

   ctrlRegSlave ctrlRegSlave_i (
      .GCLK(GCLK), .rstN(rstN),
      .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
      .wValid(wValid), .wReady(wReady), .wData(wData), .wStrb(wStrb),
      .bValid(bValid), .bReady(bReady), .bResp(bResp),
      .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
      .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
      .chanSel(chanSel)
   );

   syncTiming #(
      .hPulse(hPulse), .hBack(hBack), .hTotal(hTotal),
      .vPulse(vPulse), .vBack(vBack), .vActive(vActive), .vTotal(vTotal),
      .barCounts(barCounts)
   ) syncTiming_i (
      .GCLK(GCLK), .rstN(rstN),
      .hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw), .active(active), .bar(bar)
   );

   // One channel unit per colour, each on its 2-bit select slice
   for (genvar i = 0; i < numChannels; i++) begin : genChan
      colorChannel colorChannel_i (
         .GCLK(GCLK), .rstN(rstN),
         .bar(bar), .active(active),
         .sel(chanSel[2*i +: 2]),
         .level(chanLevel[i])
      );
   end

   pixelOutput pixelOutput_i (
      .GCLK(GCLK), .rstN(rstN),
      .hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw),
      .redIn(chanLevel[0]), .greenIn(chanLevel[1]), .blueIn(chanLevel[2]),
      .vgaHs(vgaHs), .vgaVs(vgaVs),
      .vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB)
   );

endmodule : vgaPatternTop

//--- src/vgaPkg.sv
package vgaPkg;

   // Intensity of one colour channel
   typedef logic [3:0] colorLevel;

   // Number of the colour bar under the beam, 0 at the left edge
   typedef logic [2:0] barIndex;

   // Per-channel bar select
   // 0..2 pick a bit of barIndex, 3 keeps the channel dark
   typedef logic [1:0] barSel;

   // AXI response code
   typedef logic [1:0] axiResp;

   localparam axiResp respOkay = 2'b00;
   localparam axiResp respSlvErr = 2'b10;

   // Red, green, blue
   localparam int numChannels = 3;

   // Select value for a channel that never lights
   localparam barSel selOff = 2'd3;

   // Byte address of the only control register
   localparam logic [3:0] ctrlAddr = 4'h0;

   // Reset pattern of the control register
   // Bits 1:0 red, 3:2 green, 5:4 blue
   // Red on bar bit 2, green on bit 1, blue on bit 0
   localparam logic [2*numChannels-1:0] ctrlResetValue = {2'd0, 2'd1, 2'd2};

   // Level driven for a lit channel
   localparam colorLevel fullLevel = 4'hF;

endpackage : vgaPkg
